// ==== hw/snake_motion_ctrl.sv ====
`timescale 1ns/100ps

module snake_motion_ctrl #(
	parameter int TICK_CYCLES = snake_pkg::TICK_CYCLES_DEFAULT
) (
	input  logic                   i_clk_74M,
	input  logic                   i_arst_n,
	output logic                   o_step,
	output snake_pkg::tile_coord_t o_head_x,
	output snake_pkg::tile_coord_t o_head_y,
	output snake_pkg::score_t      o_score
);

	localparam int CNT_W = $clog2(TICK_CYCLES + 1);

	logic [CNT_W-1:0]       tick_cnt;
	snake_pkg::dir_t        dir_q;
	snake_pkg::dir_t        nxt_dir;
	snake_pkg::tile_coord_t nxt_x;
	snake_pkg::tile_coord_t nxt_y;
	logic                   apple_hit;

	//////////////////////////////////////////////////////////////////////
	// Movement tick
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_74M or negedge i_arst_n) begin
		if (!i_arst_n) begin
			tick_cnt <= '0;
			o_step   <= 1'b0;
		end else begin
			o_step <= (tick_cnt == CNT_W'(TICK_CYCLES - 1));
			if (tick_cnt == CNT_W'(TICK_CYCLES - 1)) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Next head tile and direction
	//////////////////////////////////////////////////////////////////////

	// At a bound the head steps back and the direction flips
	always_comb begin
		nxt_x   = o_head_x;
		nxt_y   = o_head_y;
		nxt_dir = dir_q;
		case (dir_q)
			snake_pkg::DIR_RIGHT: begin
				if (o_head_x < snake_pkg::BOUND_HI) begin
					nxt_x = o_head_x + 1'b1;
				end else begin
					nxt_x   = o_head_x - 1'b1;
					nxt_dir = snake_pkg::DIR_LEFT;
				end
			end
			snake_pkg::DIR_LEFT: begin
				if (o_head_x > snake_pkg::BOUND_LO) begin
					nxt_x = o_head_x - 1'b1;
				end else begin
					nxt_x   = o_head_x + 1'b1;
					nxt_dir = snake_pkg::DIR_RIGHT;
				end
			end
			snake_pkg::DIR_UP: begin
				if (o_head_y > snake_pkg::BOUND_LO) begin
					nxt_y = o_head_y - 1'b1;
				end else begin
					nxt_y   = o_head_y + 1'b1;
					nxt_dir = snake_pkg::DIR_DOWN;
				end
			end
			default: begin
				if (o_head_y < snake_pkg::BOUND_HI) begin
					nxt_y = o_head_y + 1'b1;
				end else begin
					nxt_y   = o_head_y - 1'b1;
					nxt_dir = snake_pkg::DIR_UP;
				end
			end
		endcase
	end

	assign apple_hit = (nxt_x == snake_pkg::APPLE_X) && (nxt_y == snake_pkg::APPLE_Y);

	always_ff @(posedge i_clk_74M or negedge i_arst_n) begin
		if (!i_arst_n) begin
			dir_q    <= snake_pkg::DIR_START;
			o_head_x <= snake_pkg::HEAD_START_X;
			o_head_y <= snake_pkg::HEAD_START_Y;
			o_score  <= '0;
		end else if (o_step) begin
			dir_q    <= nxt_dir;
			o_head_x <= nxt_x;
			o_head_y <= nxt_y;
			// Score holds at full scale
			if (apple_hit && (o_score != '1)) begin
				o_score <= o_score + 1'b1;
			end
		end
	end

endmodule

// ==== hw/snake_pkg.sv ====
package snake_pkg;

	////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////

	typedef logic [5:0]  tile_coord_t;
	typedef logic [11:0] pix_count_t;
	typedef logic [7:0]  score_t;
	typedef logic [7:0]  colour_t;

	// Head direction of travel
	typedef enum logic [1:0] {
		DIR_RIGHT = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_UP    = 2'b10,
		DIR_DOWN  = 2'b11
	} dir_t;

	////////////////////////////////////////////////////////////////////
	// Grid, trail and timing
	////////////////////////////////////////////////////////////////////

	localparam int TILE_SHIFT = 5;
	localparam int BODY_LEN   = 16;

	localparam tile_coord_t BOUND_LO     = 6'd1;
	localparam tile_coord_t BOUND_HI     = 6'd13;
	localparam tile_coord_t HEAD_START_X = 6'd10;
	localparam tile_coord_t HEAD_START_Y = 6'd12;
	localparam dir_t        DIR_START    = DIR_UP;
	localparam tile_coord_t APPLE_X      = 6'd10;
	localparam tile_coord_t APPLE_Y      = 6'd10;

	localparam int TICK_CYCLES_DEFAULT = 25_000_000;

	////////////////////////////////////////////////////////////////////
	// Colours
	////////////////////////////////////////////////////////////////////

	localparam colour_t SNAKE_R = 8'd0;
	localparam colour_t SNAKE_G = 8'd255;
	localparam colour_t SNAKE_B = 8'd0;
	localparam colour_t APPLE_R = 8'd255;
	localparam colour_t APPLE_G = 8'd0;
	localparam colour_t APPLE_B = 8'd0;

endpackage

// ==== hw/snake_top.sv ====
`timescale 1ns/100ps

module snake_top #(
	parameter int TICK_CYCLES = snake_pkg::TICK_CYCLES_DEFAULT
) (
	input  logic                  i_clk_74M,
	input  logic                  i_arst_n,
	input  snake_pkg::pix_count_t i_hcnt,
	input  snake_pkg::pix_count_t i_vcnt,
	output snake_pkg::colour_t    o_r,
	output snake_pkg::colour_t    o_g,
	output snake_pkg::colour_t    o_b
);

	logic                   step;
	snake_pkg::tile_coord_t head_x;
	snake_pkg::tile_coord_t head_y;
	snake_pkg::score_t      score;
	logic                   snake_hit;

	snake_motion_ctrl #(
		.TICK_CYCLES(TICK_CYCLES)
	) u_motion (
		.i_clk_74M (i_clk_74M),
		.i_arst_n  (i_arst_n),
		.o_step    (step),
		.o_head_x  (head_x),
		.o_head_y  (head_y),
		.o_score   (score)
	);

	snake_trail u_trail (
		.i_clk_74M   (i_clk_74M),
		.i_arst_n    (i_arst_n),
		.i_step      (step),
		.i_head_x    (head_x),
		.i_head_y    (head_y),
		.i_score     (score),
		.i_hcnt      (i_hcnt),
		.i_vcnt      (i_vcnt),
		.o_snake_hit (snake_hit)
	);

	tile_compose u_compose (
		.i_clk_74M   (i_clk_74M),
		.i_arst_n    (i_arst_n),
		.i_snake_hit (snake_hit),
		.i_hcnt      (i_hcnt),
		.i_vcnt      (i_vcnt),
		.o_r         (o_r),
		.o_g         (o_g),
		.o_b         (o_b)
	);

endmodule

// ==== hw/snake_trail.sv ====
`timescale 1ns/100ps

module snake_trail (
	input  logic                   i_clk_74M,
	input  logic                   i_arst_n,
	input  logic                   i_step,
	input  snake_pkg::tile_coord_t i_head_x,
	input  snake_pkg::tile_coord_t i_head_y,
	input  snake_pkg::score_t      i_score,
	input  snake_pkg::pix_count_t  i_hcnt,
	input  snake_pkg::pix_count_t  i_vcnt,
	output logic                   o_snake_hit
);

	// Segment 0 is the head itself, held in the motion controller
	snake_pkg::tile_coord_t seg_x [1:snake_pkg::BODY_LEN-1];
	snake_pkg::tile_coord_t seg_y [1:snake_pkg::BODY_LEN-1];
	snake_pkg::tile_coord_t pix_x;
	snake_pkg::tile_coord_t pix_y;

	assign pix_x = snake_pkg::tile_coord_t'(i_hcnt >> snake_pkg::TILE_SHIFT);
	assign pix_y = snake_pkg::tile_coord_t'(i_vcnt >> snake_pkg::TILE_SHIFT);

	//////////////////////////////////////////////////////////////////////
	// Trail shift register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_74M or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int k = 1; k < snake_pkg::BODY_LEN; k++) begin
				seg_x[k] <= snake_pkg::HEAD_START_X;
				seg_y[k] <= snake_pkg::HEAD_START_Y;
			end
		end else if (i_step) begin
			seg_x[1] <= i_head_x;
			seg_y[1] <= i_head_y;
			for (int k = 2; k < snake_pkg::BODY_LEN; k++) begin
				seg_x[k] <= seg_x[k-1];
				seg_y[k] <= seg_y[k-1];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pixel hit test
	//////////////////////////////////////////////////////////////////////

	// Segment k only counts once k apples are eaten
	always_comb begin
		o_snake_hit = (pix_x == i_head_x) && (pix_y == i_head_y);
		for (int k = 1; k < snake_pkg::BODY_LEN; k++) begin
			if ((pix_x == seg_x[k]) && (pix_y == seg_y[k]) &&
			    (i_score >= snake_pkg::score_t'(k))) begin
				o_snake_hit = 1'b1;
			end
		end
	end

endmodule

// ==== hw/tile_compose.sv ====
`timescale 1ns/100ps

module tile_compose (
	input  logic                  i_clk_74M,
	input  logic                  i_arst_n,
	input  logic                  i_snake_hit,
	input  snake_pkg::pix_count_t i_hcnt,
	input  snake_pkg::pix_count_t i_vcnt,
	output snake_pkg::colour_t    o_r,
	output snake_pkg::colour_t    o_g,
	output snake_pkg::colour_t    o_b
);

	snake_pkg::tile_coord_t pix_x;
	snake_pkg::tile_coord_t pix_y;
	logic                   apple_tile;

	assign pix_x = snake_pkg::tile_coord_t'(i_hcnt >> snake_pkg::TILE_SHIFT);
	assign pix_y = snake_pkg::tile_coord_t'(i_vcnt >> snake_pkg::TILE_SHIFT);

	assign apple_tile = (pix_x == snake_pkg::APPLE_X) && (pix_y == snake_pkg::APPLE_Y);

	//////////////////////////////////////////////////////////////////////
	// Paint priority and output register
	//////////////////////////////////////////////////////////////////////

	// Snake over apple over black background
	always_ff @(posedge i_clk_74M or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_r <= '0;
			o_g <= '0;
			o_b <= '0;
		end else if (i_snake_hit) begin
			o_r <= snake_pkg::SNAKE_R;
			o_g <= snake_pkg::SNAKE_G;
			o_b <= snake_pkg::SNAKE_B;
		end else if (apple_tile) begin
			o_r <= snake_pkg::APPLE_R;
			o_g <= snake_pkg::APPLE_G;
			o_b <= snake_pkg::APPLE_B;
		end else begin
			o_r <= '0;
			o_g <= '0;
			o_b <= '0;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the snake testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--timescale 1ns/100ps \
	--top-module snake_tb \
	-f tb.f \
	-o snake_sim

./obj_dir/snake_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
	echo "Simulation result: PASS"
	exit 0
else
	echo "Simulation result: FAIL"
	exit 1
fi

// ==== tb.f ====
+incdir+verification
hw/snake_pkg.sv
hw/snake_motion_ctrl.sv
hw/snake_trail.sv
hw/tile_compose.sv
hw/snake_top.sv
verification/snake_tb.sv

// ==== verification/snake_vectors.svh ====
`ifndef SNAKE_VECTORS_SVH
`define SNAKE_VECTORS_SVH

localparam logic [3:0] PROBE_HEAD  = 4'd0;
localparam logic [3:0] PROBE_SEG   = 4'd1;
localparam logic [3:0] PROBE_APPLE = 4'd2;
localparam logic [3:0] PROBE_FIXED = 4'd3;

localparam logic [3:0] KIND_BLACK = 4'd0;
localparam logic [3:0] KIND_SNAKE = 4'd1;
localparam logic [3:0] KIND_APPLE = 4'd2;

localparam int NUM_ROWS = 36;

// Each row holds tick, probe kind, arg a (segment k or tile x), arg b (tile y) and expected kind
localparam logic [27:0] VECTORS [0:NUM_ROWS-1] = '{
	{8'd0,  PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd0,  PROBE_APPLE, 6'd0,  6'd0,  KIND_APPLE},
	{8'd0,  PROBE_FIXED, 6'd0,  6'd0,  KIND_BLACK},
	{8'd1,  PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd1,  PROBE_SEG,   6'd1,  6'd0,  KIND_BLACK},
	{8'd1,  PROBE_APPLE, 6'd0,  6'd0,  KIND_APPLE},
	{8'd2,  PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd2,  PROBE_SEG,   6'd1,  6'd0,  KIND_SNAKE},
	{8'd2,  PROBE_SEG,   6'd2,  6'd0,  KIND_BLACK},
	{8'd3,  PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd3,  PROBE_SEG,   6'd1,  6'd0,  KIND_SNAKE},
	{8'd3,  PROBE_SEG,   6'd2,  6'd0,  KIND_BLACK},
	{8'd11, PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd11, PROBE_SEG,   6'd1,  6'd0,  KIND_SNAKE},
	{8'd12, PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd12, PROBE_FIXED, 6'd10, 6'd3,  KIND_BLACK},
	{8'd12, PROBE_FIXED, 6'd10, 6'd0,  KIND_BLACK},
	{8'd20, PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd20, PROBE_SEG,   6'd2,  6'd0,  KIND_SNAKE},
	{8'd20, PROBE_SEG,   6'd3,  6'd0,  KIND_BLACK},
	{8'd21, PROBE_SEG,   6'd1,  6'd0,  KIND_SNAKE},
	{8'd21, PROBE_SEG,   6'd3,  6'd0,  KIND_BLACK},
	{8'd24, PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd24, PROBE_SEG,   6'd1,  6'd0,  KIND_SNAKE},
	{8'd24, PROBE_FIXED, 6'd10, 6'd11, KIND_BLACK},
	{8'd26, PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd26, PROBE_SEG,   6'd3,  6'd0,  KIND_SNAKE},
	{8'd26, PROBE_FIXED, 6'd10, 6'd14, KIND_BLACK},
	{8'd27, PROBE_SEG,   6'd4,  6'd0,  KIND_BLACK},
	{8'd27, PROBE_APPLE, 6'd0,  6'd0,  KIND_SNAKE},
	{8'd36, PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd36, PROBE_SEG,   6'd1,  6'd0,  KIND_SNAKE},
	{8'd44, PROBE_APPLE, 6'd0,  6'd0,  KIND_SNAKE},
	{8'd44, PROBE_HEAD,  6'd0,  6'd0,  KIND_SNAKE},
	{8'd45, PROBE_SEG,   6'd4,  6'd0,  KIND_SNAKE},
	{8'd45, PROBE_SEG,   6'd5,  6'd0,  KIND_BLACK}
};

`endif

// ==== verification/snake_tb.sv ====
`timescale 1ns/100ps

module snake_tb;

	`include "snake_vectors.svh"

	localparam int TICK = 64;
	localparam int RAND_PROBES = 24;
	localparam logic [3:0] KIND_MODEL = 4'd3;

	logic clk;
	logic arst_n;
	snake_pkg::pix_count_t hcnt;
	snake_pkg::pix_count_t vcnt;
	snake_pkg::colour_t r;
	snake_pkg::colour_t g;
	snake_pkg::colour_t b;

	// Reference model state
	snake_pkg::tile_coord_t m_x;
	snake_pkg::tile_coord_t m_y;
	int m_dy;
	int m_tick;
	snake_pkg::score_t m_score;
	snake_pkg::tile_coord_t hist_x [1:snake_pkg::BODY_LEN-1];
	snake_pkg::tile_coord_t hist_y [1:snake_pkg::BODY_LEN-1];

	int cyc;
	int errors;
	integer seed;

	snake_top #(
		.TICK_CYCLES(TICK)
	) dut0 (
		.i_clk_74M (clk),
		.i_arst_n  (arst_n),
		.i_hcnt    (hcnt),
		.i_vcnt    (vcnt),
		.o_r       (r),
		.o_g       (g),
		.o_b       (b)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	task automatic model_reset();
		m_x = snake_pkg::HEAD_START_X;
		m_y = snake_pkg::HEAD_START_Y;
		m_dy = -1;
		m_tick = 0;
		m_score = 8'd0;
		for (int k = 1; k < snake_pkg::BODY_LEN; k++) begin
			hist_x[k] = snake_pkg::HEAD_START_X;
			hist_y[k] = snake_pkg::HEAD_START_Y;
		end
	endtask

	task automatic model_step();
		int ny;
		for (int k = snake_pkg::BODY_LEN - 1; k > 1; k--) begin
			hist_x[k] = hist_x[k-1];
			hist_y[k] = hist_y[k-1];
		end
		hist_x[1] = m_x;
		hist_y[1] = m_y;
		ny = int'(m_y) + m_dy;
		// Bounce back off either bound
		if (ny < int'(snake_pkg::BOUND_LO) || ny > int'(snake_pkg::BOUND_HI)) begin
			m_dy = -m_dy;
			ny = int'(m_y) + m_dy;
		end
		m_y = snake_pkg::tile_coord_t'(ny);
		if (m_x == snake_pkg::APPLE_X && m_y == snake_pkg::APPLE_Y && m_score != 8'hff) begin
			m_score = m_score + 8'd1;
		end
		m_tick++;
	endtask

	function automatic logic [3:0] model_kind(snake_pkg::tile_coord_t x,
			snake_pkg::tile_coord_t y);
		logic hit;
		hit = (x == m_x) && (y == m_y);
		for (int k = 1; k < snake_pkg::BODY_LEN; k++) begin
			if (int'(m_score) >= k && x == hist_x[k] && y == hist_y[k]) begin
				hit = 1'b1;
			end
		end
		if (hit) begin
			return KIND_SNAKE;
		end else if (x == snake_pkg::APPLE_X && y == snake_pkg::APPLE_Y) begin
			return KIND_APPLE;
		end
		return KIND_BLACK;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	// Head moves on the edge after each step pulse
	task automatic clock_edge();
		@(posedge clk);
		cyc++;
		if (cyc > 1 && cyc % TICK == 1) begin
			model_step();
		end
	endtask

	task automatic check_channel(string name, snake_pkg::colour_t exp_v,
			snake_pkg::colour_t act_v);
		assert (act_v === exp_v) else begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, exp_v, act_v);
		end
	endtask

	task automatic probe_tile(snake_pkg::tile_coord_t x, snake_pkg::tile_coord_t y,
			logic [3:0] kind);
		logic [3:0] exp_kind;
		logic [4:0] off_x;
		logic [4:0] off_y;
		snake_pkg::colour_t exp_r;
		snake_pkg::colour_t exp_g;
		snake_pkg::colour_t exp_b;
		off_x = 5'($random(seed));
		off_y = 5'($random(seed));
		clock_edge();
		hcnt <= {1'b0, x, off_x};
		vcnt <= {1'b0, y, off_y};
		// Colour reflects the snake state held before the next edge
		exp_kind = (kind == KIND_MODEL) ? model_kind(x, y) : kind;
		exp_r = 8'd0;
		exp_g = 8'd0;
		exp_b = 8'd0;
		if (exp_kind == KIND_SNAKE) begin
			exp_r = snake_pkg::SNAKE_R;
			exp_g = snake_pkg::SNAKE_G;
			exp_b = snake_pkg::SNAKE_B;
		end else if (exp_kind == KIND_APPLE) begin
			exp_r = snake_pkg::APPLE_R;
			exp_g = snake_pkg::APPLE_G;
			exp_b = snake_pkg::APPLE_B;
		end
		clock_edge();
		@(negedge clk);
		check_channel("o_r", exp_r, r);
		check_channel("o_g", exp_g, g);
		check_channel("o_b", exp_b, b);
	endtask

	initial begin
		logic [27:0] row;
		int row_tick;
		int wait_cycles;
		snake_pkg::tile_coord_t px;
		snake_pkg::tile_coord_t py;
		seed = 32'hb28b;
		errors = 0;
		cyc = 0;
		arst_n <= 1'b0;
		hcnt <= {1'b0, snake_pkg::HEAD_START_X, 5'd3};
		vcnt <= {1'b0, snake_pkg::HEAD_START_Y, 5'd3};
		model_reset();
		@(posedge clk);
		@(negedge clk);
		check_channel("o_r", 8'd0, r);
		check_channel("o_g", 8'd0, g);
		check_channel("o_b", 8'd0, b);
		@(posedge clk);
		arst_n <= 1'b1;

		for (int i = 0; i < NUM_ROWS; i++) begin
			row = VECTORS[i];
			row_tick = int'(row[27:20]);
			while (m_tick < row_tick) begin
				clock_edge();
			end
			px = row[15:10];
			py = row[9:4];
			if (row[19:16] == PROBE_HEAD) begin
				px = m_x;
				py = m_y;
			end else if (row[19:16] == PROBE_SEG) begin
				px = hist_x[int'(row[15:10])];
				py = hist_y[int'(row[15:10])];
			end else if (row[19:16] == PROBE_APPLE) begin
				px = snake_pkg::APPLE_X;
				py = snake_pkg::APPLE_Y;
			end
			assert (model_kind(px, py) == row[3:0]) else begin
				errors++;
				$display("Row %0d: the table and the reference model disagree on tile (%0d,%0d)",
					i, px, py);
			end
			probe_tile(px, py, row[3:0]);
		end

		// Random tiles near the snake column at random ticks
		for (int i = 0; i < RAND_PROBES; i++) begin
			wait_cycles = $random(seed) & 63;
			repeat (wait_cycles) clock_edge();
			px = 6'(8 + ($random(seed) & 3));
			py = 6'($random(seed) & 15);
			probe_tile(px, py, KIND_MODEL);
		end

		$display("Checks done with %0d errors", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		longint limit_ns;
		limit_ns = 2 * (longint'(VECTORS[NUM_ROWS-1][27:20]) + RAND_PROBES + 2) * TICK * 10;
		#(limit_ns);
		$display("Timeout: the run did not finish within %0d ns", limit_ns);
		$display("Testbench failed");
		$finish;
	end

endmodule
